/* common/apu_reg_pkg.sv */
package apu_reg_pkg;

  ////////////////////
  // Bus types.
  ////////////////////

  typedef logic [15:0] apu_addr_t;   // CPU register address.
  typedef logic [7:0]  apu_data_t;   // Write data byte.

  ////////////////////
  // Register fields.
  ////////////////////

  typedef logic [1:0] duty_t;          // Duty-cycle select.
  typedef logic [2:0] sweep_period_t;  // Sweep divider period.
  typedef logic [2:0] shift_t;         // Sweep shift count.
  typedef logic [4:0] length_index_t;  // Index into the length table.

  // Each channel owns base+0 to base+3.
  localparam apu_addr_t PULSE0_BASE = 16'h4000;
  localparam apu_addr_t PULSE1_BASE = 16'h4004;

  // Bit n enables channel n.
  localparam apu_addr_t STATUS_ADDR = 16'h4015;

endpackage : apu_reg_pkg

/* common/apu_audio_pkg.sv */
package apu_audio_pkg;

  typedef logic [3:0]  volume_t;        // Sample or volume level.
  typedef logic [10:0] timer_period_t;  // Pulse timer period.
  typedef logic [7:0]  length_t;        // Length count.

  // Write port handshake states.
  typedef enum logic [1:0] {
    IDLE,
    STROBE,
    HOLD
  } port_state_t;

  // Periods below this are inaudible, so the channel is muted.
  localparam timer_period_t MUTE_MIN_PERIOD = 11'd8;

endpackage : apu_audio_pkg

/* rtl/apu_bus_port.sv */
`timescale 1ns/1ps

module apu_bus_port (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  apu_reg_pkg::apu_addr_t addr,
  input  apu_reg_pkg::apu_data_t wdata,
  output logic                   ack,
  output logic                   we,
  output apu_reg_pkg::apu_addr_t waddr,
  output apu_reg_pkg::apu_data_t wd
);
  import apu_audio_pkg::*;

  port_state_t state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (req) state <= STROBE;
        STROBE:  state <= HOLD;
        HOLD:    if (!req) state <= IDLE;  // Wait for the host to drop req.
        default: state <= IDLE;
      endcase
    end
  end

  // Address and data are stable while req is high.
  always_ff @(posedge clk) begin
    if (state == IDLE && req) begin
      waddr <= addr;
      wd    <= wdata;
    end
  end

  assign we  = (state == STROBE);
  assign ack = (state == HOLD);

  // Host holds address and data for the whole request.
  a_stable_while_req : assert property (@(posedge clk) disable iff (!rst_n)
    (req && $past(req)) |-> ($stable(addr) && $stable(wdata)));

endmodule : apu_bus_port

/* rtl/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer #(
  parameter int FRAME_STEP = 7457
) (
  input  logic clk,
  input  logic rst_n,
  output logic apu_en,
  output logic quarter_en,
  output logic half_en
);

  localparam int CNT_W = $clog2(FRAME_STEP);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(FRAME_STEP - 1);

  logic [CNT_W-1:0] q_cnt;
  logic             half_tog;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      apu_en     <= 1'b0;
      q_cnt      <= '0;
      quarter_en <= 1'b0;
      half_tog   <= 1'b0;
      half_en    <= 1'b0;
    end else begin
      apu_en     <= ~apu_en;  // APU runs at half the CPU rate.
      quarter_en <= 1'b0;
      half_en    <= 1'b0;
      if (q_cnt == LAST) begin
        q_cnt      <= '0;
        quarter_en <= 1'b1;
        half_en    <= half_tog;  // Every second quarter frame.
        half_tog   <= ~half_tog;
      end else begin
        q_cnt <= q_cnt + 1'b1;
      end
    end
  end

endmodule : frame_sequencer

/* pulse/pulse_regs.sv */
`timescale 1ns/1ps

module pulse_regs #(
  parameter int CHANNEL = 0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          we,
  input  apu_reg_pkg::apu_addr_t        waddr,
  input  apu_reg_pkg::apu_data_t        wd,
  input  logic                          sweep_update,
  input  apu_audio_pkg::timer_period_t  sweep_period,
  output apu_reg_pkg::duty_t            duty,
  output logic                          length_halt,
  output logic                          const_volume,
  output apu_audio_pkg::volume_t        volume,
  output logic                          sweep_enable,
  output logic                          sweep_negate,
  output apu_reg_pkg::sweep_period_t    sweep_div,
  output apu_reg_pkg::shift_t           sweep_shift,
  output apu_audio_pkg::timer_period_t  timer_period,
  output apu_reg_pkg::length_index_t    length_index,
  output logic                          enable,
  output logic                          env_load,
  output logic                          sweep_load,
  output logic                          length_load
);
  import apu_reg_pkg::*;

  localparam apu_addr_t BASE       = (CHANNEL == 0) ? PULSE0_BASE : PULSE1_BASE;
  localparam apu_addr_t ADDR_CTRL  = BASE;
  localparam apu_addr_t ADDR_SWEEP = BASE + 16'd1;
  localparam apu_addr_t ADDR_LO    = BASE + 16'd2;
  localparam apu_addr_t ADDR_HI    = BASE + 16'd3;

  logic wr_ctrl, wr_sweep, wr_lo, wr_hi, wr_status;

  always_comb begin
    wr_ctrl   = we && (waddr == ADDR_CTRL);
    wr_sweep  = we && (waddr == ADDR_SWEEP);
    wr_lo     = we && (waddr == ADDR_LO);
    wr_hi     = we && (waddr == ADDR_HI);
    wr_status = we && (waddr == STATUS_ADDR);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      duty         <= '0;
      length_halt  <= 1'b0;
      const_volume <= 1'b0;
      volume       <= '0;
      sweep_enable <= 1'b0;
      sweep_negate <= 1'b0;
      sweep_div    <= '0;
      sweep_shift  <= '0;
      timer_period <= '0;
      length_index <= '0;
      enable       <= 1'b0;
      env_load     <= 1'b0;
      sweep_load   <= 1'b0;
      length_load  <= 1'b0;
    end else begin
      env_load    <= wr_ctrl;
      sweep_load  <= wr_sweep;
      length_load <= wr_hi;

      if (wr_ctrl) begin
        duty         <= wd[7:6];
        length_halt  <= wd[5];
        const_volume <= wd[4];
        volume       <= wd[3:0];
      end

      if (wr_sweep) begin  // EPPP NSSS.
        sweep_enable <= wd[7];
        sweep_div    <= wd[6:4];
        sweep_negate <= wd[3];
        sweep_shift  <= wd[2:0];
      end

      // A CPU write to the period beats a sweep update.
      if (wr_lo) begin
        timer_period[7:0] <= wd;
      end else if (wr_hi) begin
        timer_period[10:8] <= wd[2:0];
        length_index       <= wd[7:3];
      end else if (sweep_update) begin
        timer_period <= sweep_period;
      end

      if (wr_status) enable <= wd[CHANNEL];
    end
  end

  // Each write must arrive as a single-cycle strobe.
  a_we_one_cycle : assert property (@(posedge clk) disable iff (!rst_n) we |=> !we);

endmodule : pulse_regs

/* pulse/envelope.sv */
`timescale 1ns/1ps

module envelope (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   quarter_en,
  input  logic                   start,
  input  logic                   loop,
  input  logic                   const_volume,
  input  apu_audio_pkg::volume_t volume,
  output apu_audio_pkg::volume_t level
);
  import apu_audio_pkg::*;

  logic    start_flag;
  volume_t divider;
  volume_t decay;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_flag <= 1'b0;
      divider    <= '0;
      decay      <= '0;
    end else begin
      if (start) start_flag <= 1'b1;
      else if (quarter_en) start_flag <= 1'b0;

      if (quarter_en) begin
        if (start_flag) begin
          decay   <= 4'd15;
          divider <= volume;
        end else if (divider == '0) begin
          divider <= volume;  // Volume sets the decay rate.
          if (decay != '0) decay <= decay - 1'b1;
          else if (loop) decay <= 4'd15;
        end else begin
          divider <= divider - 1'b1;
        end
      end
    end
  end

  assign level = const_volume ? volume : decay;

endmodule : envelope

/* pulse/sweep_unit.sv */
`timescale 1ns/1ps

module sweep_unit #(
  parameter int CHANNEL = 0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          half_en,
  input  logic                          load,
  input  logic                          enable,
  input  logic                          negate,
  input  apu_reg_pkg::sweep_period_t    div,
  input  apu_reg_pkg::shift_t           shift,
  input  apu_audio_pkg::timer_period_t  period_in,
  output logic                          mute,
  output logic                          update,
  output apu_audio_pkg::timer_period_t  period_out
);
  import apu_reg_pkg::*;
  import apu_audio_pkg::*;

  // Channel 0 negates with ones' complement, so one more comes off.
  localparam logic [11:0] NEG_CARRY = (CHANNEL == 0) ? 12'd1 : 12'd0;

  sweep_period_t div_cnt;
  logic          reload;
  logic [11:0]   change;
  logic [11:0]   target;

  always_comb begin
    change = {1'b0, period_in >> shift};
    if (negate) target = {1'b0, period_in} - change - NEG_CARRY;
    else target = {1'b0, period_in} + change;
  end

  // Any result past 11 bits, an underflow included, mutes.
  assign mute       = (period_in < MUTE_MIN_PERIOD) || (target > 12'h7FF);
  assign period_out = target[10:0];
  assign update     = half_en && (div_cnt == '0) && enable && (shift != '0) && !mute;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      reload  <= 1'b0;
    end else begin
      if (load) reload <= 1'b1;
      else if (half_en) reload <= 1'b0;

      if (half_en) begin
        if (div_cnt == '0 || reload) div_cnt <= div;
        else div_cnt <= div_cnt - 1'b1;
      end
    end
  end

endmodule : sweep_unit

/* pulse/length_counter.sv */
`timescale 1ns/1ps

module length_counter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       half_en,
  input  logic                       load,
  input  apu_reg_pkg::length_index_t index,
  input  logic                       halt,
  input  logic                       enable,
  output logic                       non_zero
);
  import apu_audio_pkg::*;

  localparam length_t LENGTH_TABLE [32] = '{
    8'd10,  8'd254, 8'd20,  8'd2,  8'd40, 8'd4,  8'd80, 8'd6,
    8'd160, 8'd8,   8'd60,  8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
    8'd12,  8'd16,  8'd24,  8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
    8'd192, 8'd24,  8'd72,  8'd26, 8'd16, 8'd28, 8'd32, 8'd30
  };

  length_t count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (!enable) begin
      count <= '0;  // Disabled channel is silenced at once.
    end else if (load) begin
      count <= LENGTH_TABLE[index];
    end else if (half_en && !halt && count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign non_zero = (count != '0);

endmodule : length_counter

/* pulse/pulse_channel.sv */
`timescale 1ns/1ps

module pulse_channel #(
  parameter int CHANNEL = 0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          apu_en,
  input  logic                          quarter_en,
  input  logic                          half_en,
  input  apu_reg_pkg::duty_t            duty,
  input  logic                          length_halt,
  input  logic                          const_volume,
  input  apu_audio_pkg::volume_t        volume,
  input  logic                          sweep_enable,
  input  logic                          sweep_negate,
  input  apu_reg_pkg::sweep_period_t    sweep_div,
  input  apu_reg_pkg::shift_t           sweep_shift,
  input  apu_audio_pkg::timer_period_t  timer_period,
  input  apu_reg_pkg::length_index_t    length_index,
  input  logic                          enable,
  input  logic                          env_load,
  input  logic                          sweep_load,
  input  logic                          length_load,
  output logic                          sweep_update,
  output apu_audio_pkg::timer_period_t  sweep_period,
  output logic                          length_non_zero,
  output apu_audio_pkg::volume_t        sample
);
  import apu_audio_pkg::*;

  timer_period_t timer_cnt;
  logic [2:0]    seq_idx;
  logic [7:0]    seq_pattern;
  logic          seq_bit;
  logic          mute;
  volume_t       env_level;

  ////////////////////
  // Timer and sequencer.
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timer_cnt <= '0;
      seq_idx   <= '0;
    end else begin
      if (apu_en) timer_cnt <= (timer_cnt == '0) ? timer_period : timer_cnt - 1'b1;
      if (length_load) seq_idx <= '0;  // New note restarts the waveform.
      else if (apu_en && timer_cnt == '0) seq_idx <= seq_idx + 1'b1;
    end
  end

  always_comb begin
    case (duty)
      2'd0:    seq_pattern = 8'b0000_0010;  // 12.5%.
      2'd1:    seq_pattern = 8'b0000_0110;  // 25%.
      2'd2:    seq_pattern = 8'b0001_1110;  // 50%.
      default: seq_pattern = 8'b1111_1001;  // 75%.
    endcase
    seq_bit = seq_pattern[seq_idx];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) sample <= '0;
    else if (mute || !seq_bit || !length_non_zero) sample <= '0;
    else sample <= env_level;
  end

  ////////////////////
  // Frame-clocked units.
  ////////////////////

  envelope u_env (
    .clk,
    .rst_n,
    .quarter_en,
    .start(env_load),
    .loop(length_halt),  // Halt doubles as envelope loop.
    .const_volume,
    .volume,
    .level(env_level)
  );

  sweep_unit #(.CHANNEL(CHANNEL)) u_sweep (
    .clk,
    .rst_n,
    .half_en,
    .load(sweep_load),
    .enable(sweep_enable),
    .negate(sweep_negate),
    .div(sweep_div),
    .shift(sweep_shift),
    .period_in(timer_period),
    .mute,
    .update(sweep_update),
    .period_out(sweep_period)
  );

  length_counter u_len (
    .clk,
    .rst_n,
    .half_en,
    .load(length_load),
    .index(length_index),
    .halt(length_halt),
    .enable,
    .non_zero(length_non_zero)
  );

endmodule : pulse_channel

/* rtl/apu_pulse_top.sv */
`timescale 1ns/1ps

module apu_pulse_top #(
  parameter int FRAME_STEP = 7457
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  apu_reg_pkg::apu_addr_t addr,
  input  apu_reg_pkg::apu_data_t wdata,
  output logic                   ack,
  output apu_audio_pkg::volume_t out0,
  output apu_audio_pkg::volume_t out1,
  output logic [1:0]             length_status
);
  import apu_reg_pkg::*;
  import apu_audio_pkg::*;

  logic      we;
  apu_addr_t waddr;
  apu_data_t wd;
  logic      apu_en, quarter_en, half_en;
  volume_t   sample [2];

  apu_bus_port u_bus (
    .clk,
    .rst_n,
    .req,
    .addr,
    .wdata,
    .ack,
    .we,
    .waddr,
    .wd
  );

  frame_sequencer #(.FRAME_STEP(FRAME_STEP)) u_frame (
    .clk,
    .rst_n,
    .apu_en,
    .quarter_en,
    .half_en
  );

  ////////////////////
  // Pulse channels.
  ////////////////////

  for (genvar i = 0; i < 2; i++) begin : g_pulse
    duty_t         duty;
    logic          length_halt, const_volume;
    volume_t       volume;
    logic          sweep_enable, sweep_negate;
    sweep_period_t sweep_div;
    shift_t        sweep_shift;
    timer_period_t timer_period, sweep_period;
    length_index_t length_index;
    logic          enable, env_load, sweep_load, length_load, sweep_update;

    pulse_regs #(.CHANNEL(i)) u_regs (
      .clk, .rst_n, .we, .waddr, .wd,
      .sweep_update, .sweep_period,
      .duty, .length_halt, .const_volume, .volume,
      .sweep_enable, .sweep_negate, .sweep_div, .sweep_shift,
      .timer_period, .length_index, .enable,
      .env_load, .sweep_load, .length_load
    );

    pulse_channel #(.CHANNEL(i)) u_chan (
      .clk, .rst_n, .apu_en, .quarter_en, .half_en,
      .duty, .length_halt, .const_volume, .volume,
      .sweep_enable, .sweep_negate, .sweep_div, .sweep_shift,
      .timer_period, .length_index, .enable,
      .env_load, .sweep_load, .length_load,
      .sweep_update, .sweep_period,
      .length_non_zero(length_status[i]),
      .sample(sample[i])
    );
  end

  assign out0 = sample[0];
  assign out1 = sample[1];

endmodule : apu_pulse_top

/* test/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;  // Released on a rising edge.
  end

endmodule : clock_gen

/* test/tb_apu_pulse.sv */
`timescale 1ns/1ps

module tb_apu_pulse;
  import apu_reg_pkg::*;
  import apu_audio_pkg::*;

  localparam int FRAME_STEP = 16;
  localparam int TRIALS     = 6;
  localparam int WRITE_CYC  = 10;
  localparam int SETTLE     = 140;  // Longer than one reload of the largest old period.
  localparam int WINDOW_MAX = 16 * 64;
  localparam volume_t       ENV_VOL    = 4'd5;
  localparam timer_period_t ENV_PERIOD = 11'd8;
  localparam int ENV_CYC = 16 * (int'(ENV_VOL) + 1) * FRAME_STEP + 64 * (int'(ENV_PERIOD) + 1);
  localparam int CYCLE_LIMIT = 40 + WRITE_CYC
    + 2 * (5 * WRITE_CYC + SETTLE + WINDOW_MAX)
    + 2 * TRIALS * (4 * WRITE_CYC + SETTLE + WINDOW_MAX)
    + 2 * (4 * WRITE_CYC + 256 * 2 * FRAME_STEP)
    + 2 * (6 * WRITE_CYC + FRAME_STEP + ENV_CYC)
    + 500;

  logic       clk, rst_n, req, ack;
  apu_addr_t  addr;
  apu_data_t  wdata;
  volume_t    out0, out1;
  logic [1:0] length_status;

  int         cycle = 0;
  int         seed;
  int         mismatches = 0;
  int         we_count = 0;
  int         we_cycle = 0;
  int         rise_count [2] = '{0, 0};
  int         fall_count [2] = '{0, 0};
  int         rise_cycle [2] = '{0, 0};
  int         fall_cycle [2] = '{0, 0};
  logic [1:0] last_status = 2'b00;
  logic [1:0] enables;

  clock_gen #(.HALF_PERIOD(4), .RESET_CYCLES(4)) u_clk (.clk, .rst_n);

  apu_pulse_top #(.FRAME_STEP(FRAME_STEP)) DUT (
    .clk, .rst_n, .req, .addr, .wdata, .ack, .out0, .out1, .length_status
  );

  ////////////////////
  // Reference model.
  ////////////////////

  function automatic int duty_high(duty_t d);
    case (d)
      2'd0:    return 1;
      2'd1:    return 2;
      2'd2:    return 4;
      default: return 6;
    endcase
  endfunction

  function automatic bit sweep_target_mutes(int ch, timer_period_t p, shift_t s, bit negate);
    int target;
    if (negate) target = int'(p) - (int'(p) >> s) - ((ch == 0) ? 1 : 0);
    else target = int'(p) + (int'(p) >> s);
    return (p < MUTE_MIN_PERIOD) || (target > 2047) || (target < 0);
  endfunction

  function automatic int length_value(length_index_t idx);
    int n;
    n = int'(idx[3:1]);
    if (idx[0]) return (idx == 5'd1) ? 254 : int'(idx) - 1;
    if (n < 5) return (idx[4] ? 12 : 10) << n;  // Note lengths double per step.
    case (n)
      5:       return idx[4] ? 72 : 60;
      6:       return idx[4] ? 16 : 14;
      default: return idx[4] ? 32 : 26;
    endcase
  endfunction

  function automatic int pick_below(int n);
    return {$random(seed)} % n;
  endfunction

  ////////////////////
  // Checks.
  ////////////////////

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_sample(input string what, input volume_t got, input volume_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
      stop_run("Sample check failed");
    end
  endtask

  task automatic check_status(input string what, input logic [1:0] got,
                              input logic [1:0] exp, input logic [1:0] mask);
    if ((got & mask) !== (exp & mask)) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got & mask, exp & mask);
      stop_run("Length status check failed");
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
      stop_run("Handshake check failed");
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
      stop_run("Count check failed");
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > CYCLE_LIMIT) stop_run("Timeout: the run went past its cycle limit");
  end

  // Strobe and length status edge monitor.
  always @(negedge clk) begin
    if (rst_n && DUT.we) begin
      we_count = we_count + 1;
      we_cycle = cycle;
    end
    for (int i = 0; i < 2; i++) begin
      if (length_status[i] && !last_status[i]) begin
        rise_count[i] = rise_count[i] + 1;
        rise_cycle[i] = cycle;
      end
      if (!length_status[i] && last_status[i]) begin
        fall_count[i] = fall_count[i] + 1;
        fall_cycle[i] = cycle;
      end
    end
    last_status = length_status;
  end

  ////////////////////
  // Stimulus tasks.
  ////////////////////

  task automatic write_reg(input apu_addr_t a, input apu_data_t d, input int hold);
    int   n;
    int   start_writes;
    logic seen;
    start_writes = we_count;
    @(posedge clk);
    req   <= 1'b1;
    addr  <= a;
    wdata <= d;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 8) begin
      @(posedge clk);
      n++;
      @(negedge clk);
      seen = ack;
    end
    if (!seen || n > 2) stop_run("Bus port did not raise ack within 2 cycles of req");
    repeat (hold) begin
      @(negedge clk);
      check_level("ack while req held", ack, 1'b1);
    end
    @(posedge clk);
    if (we_count != start_writes + 1) stop_run("One request gave other than one write strobe");
    req <= 1'b0;
    @(negedge clk);
    check_level("ack in the cycle req drops", ack, 1'b1);
    @(negedge clk);
    check_level("ack one cycle after req drops", ack, 1'b0);
  endtask

  task automatic set_enable(input int ch, input logic on);
    enables[ch] = on;
    write_reg(STATUS_ADDR, {6'd0, enables}, 0);
  endtask

  task automatic setup_channel(input int ch, input apu_data_t ctrl, input apu_data_t sweep,
                               input timer_period_t p, input length_index_t idx);
    apu_addr_t base;
    base = (ch == 0) ? PULSE0_BASE : PULSE1_BASE;
    write_reg(base + 16'd1, sweep, 0);
    write_reg(base + 16'd2, p[7:0], 0);
    write_reg(base, ctrl, 0);
    write_reg(base + 16'd3, {idx, p[10:8]}, 0);
  endtask

  task automatic check_duty_window(input int ch, input timer_period_t p, input volume_t v,
                                   input duty_t d, input bit muted);
    int      high;
    int      span;
    volume_t s;
    high = 0;
    span = 16 * (int'(p) + 1);  // One full sequencer loop.
    repeat (SETTLE) @(negedge clk);
    repeat (span) begin
      @(negedge clk);
      s = (ch == 0) ? out0 : out1;
      if (s != '0) begin
        check_sample("duty sample", s, muted ? 4'd0 : v);
        high++;
      end
    end
    check_count("high cycles in window", high, muted ? 0 : duty_high(d) * 2 * (int'(p) + 1));
  endtask

  task automatic check_envelope(input int ch);
    volume_t s;
    volume_t last;
    bit      seen;
    int      zeros;
    seen  = 1'b0;
    last  = 4'd15;
    zeros = 0;
    repeat (ENV_CYC) begin
      @(negedge clk);
      s = (ch == 0) ? out0 : out1;
      if (s == '0) begin
        zeros++;
      end else begin
        zeros = 0;
        if (!seen) check_sample("first envelope level", s, 4'd15);
        else if (s > last) check_sample("envelope level rose", s, last);
        seen = 1'b1;
        last = s;
      end
    end
    if (!seen) stop_run("Envelope output never became nonzero");
    if (zeros < 16 * (int'(ENV_PERIOD) + 1)) stop_run("Envelope output did not decay to zero");
  endtask

  ////////////////////
  // Test sequence.
  ////////////////////

  initial begin
    duty_t         d;
    volume_t       v;
    timer_period_t p;
    shift_t        sh;
    length_index_t idx;
    apu_addr_t     base;
    logic [1:0]    bit_mask;
    int            len;
    int            old_count;
    req     = 1'b0;
    addr    = '0;
    wdata   = '0;
    enables = 2'b00;
    seed    = 32'h0d20_b7f1;
    wait (rst_n === 1'b1);
    @(negedge clk);

    check_level("ack after reset", ack, 1'b0);
    write_reg(STATUS_ADDR, 8'h00, 5);  // Long req must not write twice.

    set_enable(0, 1'b1);
    set_enable(1, 1'b1);
    for (int ch = 0; ch < 2; ch++) begin
      d = duty_t'(pick_below(4));
      v = volume_t'(1 + pick_below(15));
      p = timer_period_t'(8 + pick_below(56));
      setup_channel(ch, {d, 2'b11, v}, 8'h00, p, 5'd1);
      check_duty_window(ch, p, v, d, 1'b0);
    end

    // Shift 0 with negate mutes only channel 0.
    for (int ch = 0; ch < 2; ch++) begin
      for (int t = 0; t < TRIALS; t++) begin
        d  = duty_t'(pick_below(4));
        v  = volume_t'(1 + pick_below(15));
        sh = (t == 0) ? 3'd0 : shift_t'(pick_below(8));
        if (t == 0) p = timer_period_t'(8 + pick_below(32));
        else if (t == 1) p = timer_period_t'(pick_below(8));
        else p = timer_period_t'(pick_below(40));
        setup_channel(ch, {d, 2'b11, v}, {4'b0000, 1'b1, sh}, p, 5'd1);
        check_duty_window(ch, p, v, d, sweep_target_mutes(ch, p, sh, 1'b1));
      end
    end

    for (int ch = 0; ch < 2; ch++) begin
      base     = (ch == 0) ? PULSE0_BASE : PULSE1_BASE;
      bit_mask = 2'b01 << ch;
      old_count = fall_count[ch];
      set_enable(ch, 1'b0);
      if (fall_count[ch] != old_count + 1) stop_run("Length status did not drop on disable");
      if (fall_cycle[ch] - we_cycle > 2) stop_run("Length status dropped too late on disable");
      write_reg(base, 8'h9F, 0);  // Halt clear.
      set_enable(ch, 1'b1);
      idx = length_index_t'(pick_below(32));
      len = length_value(idx);
      old_count = rise_count[ch];
      write_reg(base + 16'd3, {idx, 3'd0}, 0);
      if (rise_count[ch] != old_count + 1) stop_run("Length status did not rise on load");
      if (rise_cycle[ch] - we_cycle > 2) stop_run("Length status rose too late on load");
      while (cycle < rise_cycle[ch] + (len - 1) * 2 * FRAME_STEP) @(negedge clk);
      check_status("length status before expiry", length_status, bit_mask, bit_mask);
      while (cycle < rise_cycle[ch] + (len + 1) * 2 * FRAME_STEP) @(negedge clk);
      check_status("length status after expiry", length_status, 2'b00, bit_mask);
    end

    for (int ch = 0; ch < 2; ch++) begin
      base = (ch == 0) ? PULSE0_BASE : PULSE1_BASE;
      set_enable(ch, 1'b0);
      write_reg(base + 16'd1, 8'h00, 0);
      write_reg(base + 16'd2, ENV_PERIOD[7:0], 0);
      write_reg(base, {2'd3, 2'b00, ENV_VOL}, 0);
      repeat (FRAME_STEP) @(negedge clk);  // Let a quarter frame restart the decay.
      set_enable(ch, 1'b1);
      write_reg(base + 16'd3, {5'd1, ENV_PERIOD[10:8]}, 0);
      check_envelope(ch);
    end

    if (mismatches == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      stop_run("Checks failed");
    end
  end

endmodule : tb_apu_pulse

/* list.f */
common/apu_reg_pkg.sv
common/apu_audio_pkg.sv
rtl/apu_bus_port.sv
rtl/frame_sequencer.sv
pulse/pulse_regs.sv
pulse/envelope.sv
pulse/sweep_unit.sv
pulse/length_counter.sv
pulse/pulse_channel.sv
rtl/apu_pulse_top.sv
test/clock_gen.sv
test/tb_apu_pulse.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_apu_pulse

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_apu_pulse --Mdir obj_dir -o "$BIN" -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "NO ERRORS" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
